/* compile.f */
verilog/soc_pkg.sv
verilog/apb_decoder.sv
verilog/data_ram.sv
verilog/gpio.sv
verilog/uart.sv
verilog/soc_periph.sv
test/soc_periph_asserts.sv
test/soc_periph_tb.sv

/* test/soc_periph_tb.sv */
/*
 * Table-driven APB testbench for soc_periph with uart_tx looped back to
 * uart_rx. Inputs change on the falling clock edge. RAM depth fixed at 256.
 */
module soc_periph_tb;

    localparam int CLKS_PER_BIT = 8;
    localparam int MAX_ENTRIES  = 40;
    localparam int POLL_LIMIT   = 40 * CLKS_PER_BIT;
    localparam int OP_WRITE     = 0;
    localparam int OP_READ      = 1;
    localparam int OP_POLL      = 2;

    localparam soc_pkg::addr_t GPIO_OUT  = soc_pkg::GPIO_BASE + 32'(soc_pkg::GPIO_OUT_OFS);
    localparam soc_pkg::addr_t GPIO_IN   = soc_pkg::GPIO_BASE + 32'(soc_pkg::GPIO_IN_OFS);
    localparam soc_pkg::addr_t UART_TX   = soc_pkg::UART_BASE + 32'(soc_pkg::UART_TXDATA_OFS);
    localparam soc_pkg::addr_t UART_STAT = soc_pkg::UART_BASE + 32'(soc_pkg::UART_STATUS_OFS);
    localparam soc_pkg::addr_t UART_RX   = soc_pkg::UART_BASE + 32'(soc_pkg::UART_RXDATA_OFS);

    logic           clk;
    logic           rst_n;
    logic           psel;
    logic           penable;
    logic           pwrite;
    soc_pkg::addr_t paddr;
    soc_pkg::data_t pwdata;
    soc_pkg::data_t prdata;
    logic           pready;
    logic           pslverr;
    soc_pkg::gpio_t gpio_in;
    soc_pkg::gpio_t gpio_out;
    logic           uart_line;

    // Stimulus table, a poll entry keeps its bit mask in exp_data
    string          names    [MAX_ENTRIES];
    int             ops      [MAX_ENTRIES];
    soc_pkg::addr_t addrs    [MAX_ENTRIES];
    soc_pkg::data_t datas    [MAX_ENTRIES];
    soc_pkg::data_t exp_data [MAX_ENTRIES];
    logic           exp_err  [MAX_ENTRIES];
    int             n_entries;
    int             test_errors;
    int             pass_count;
    int             fail_count;
    int             seed;
    logic           table_done;

    soc_periph #(
        .RAM_ADDR_WIDTH (8),
        .CLKS_PER_BIT   (CLKS_PER_BIT)
    ) soc_periph_i (
        .clk      (clk),
        .rst_n    (rst_n),
        .psel     (psel),
        .penable  (penable),
        .pwrite   (pwrite),
        .paddr    (paddr),
        .pwdata   (pwdata),
        .prdata   (prdata),
        .pready   (pready),
        .pslverr  (pslverr),
        .gpio_in  (gpio_in),
        .gpio_out (gpio_out),
        .uart_rx  (uart_line),
        .uart_tx  (uart_line)
    );

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    task automatic add_entry(input string name, input int op, input soc_pkg::addr_t addr,
                             input soc_pkg::data_t data, input soc_pkg::data_t expd,
                             input logic err);
        names[n_entries]    = name;
        ops[n_entries]      = op;
        addrs[n_entries]    = addr;
        datas[n_entries]    = data;
        exp_data[n_entries] = expd;
        exp_err[n_entries]  = err;
        n_entries++;
    endtask

    task automatic build_table();
        soc_pkg::data_t      w0;
        soc_pkg::data_t      w1;
        soc_pkg::data_t      w2;
        soc_pkg::data_t      w3;
        soc_pkg::data_t      gp;
        soc_pkg::gpio_t      gi;
        soc_pkg::uart_byte_t b0;
        soc_pkg::uart_byte_t b1;
        w0 = $random(seed);
        w1 = $random(seed);
        w2 = $random(seed);
        w3 = $random(seed);
        gp = $random(seed);
        gi = 8'($random(seed));
        b0 = 8'($random(seed));
        b1 = 8'($random(seed));
        add_entry("ram write first word", OP_WRITE, 32'h000, w0, '0, 1'b0);
        add_entry("ram write last word", OP_WRITE, 32'h3fc, w1, '0, 1'b0);
        add_entry("ram write middle word", OP_WRITE, 32'h010, w2, '0, 1'b0);
        add_entry("ram overwrite middle word", OP_WRITE, 32'h010, w3, '0, 1'b0);
        add_entry("ram read first word", OP_READ, 32'h000, '0, w0, 1'b0);
        add_entry("ram read last word", OP_READ, 32'h3fc, '0, w1, 1'b0);
        add_entry("ram read middle word", OP_READ, 32'h010, '0, w3, 1'b0);
        add_entry("gpio out write", OP_WRITE, GPIO_OUT, gp, '0, 1'b0);
        add_entry("gpio out read back", OP_READ, GPIO_OUT, '0, {24'd0, gp[7:0]}, 1'b0);
        add_entry("gpio in read", OP_READ, GPIO_IN, {24'd0, gi}, {24'd0, gi}, 1'b0);
        add_entry("gpio in write ignored", OP_WRITE, GPIO_IN, {24'd0, ~gi}, '0, 1'b0);
        add_entry("gpio in read again", OP_READ, GPIO_IN, {24'd0, gi}, {24'd0, gi}, 1'b0);
        add_entry("uart send byte", OP_WRITE, UART_TX, {24'd0, b0}, '0, 1'b0);
        add_entry("uart wait rx_valid", OP_POLL, UART_STAT, '0, 32'h2, 1'b0);
        add_entry("uart read byte", OP_READ, UART_RX, '0, {24'd0, b0}, 1'b0);
        add_entry("uart rx_valid cleared", OP_READ, UART_STAT, '0, '0, 1'b0);
        add_entry("uart send first byte", OP_WRITE, UART_TX, {24'd0, b1}, '0, 1'b0);
        add_entry("uart send while busy", OP_WRITE, UART_TX, {24'd0, ~b1}, '0, 1'b0);
        add_entry("uart wait busy frame", OP_POLL, UART_STAT, '0, 32'h2, 1'b0);
        add_entry("uart first byte kept", OP_READ, UART_RX, '0, {24'd0, b1}, 1'b0);
        add_entry("uart idle after busy test", OP_READ, UART_STAT, '0, '0, 1'b0);
        add_entry("ram word before decode errors", OP_READ, 32'h000, '0, w0, 1'b0);
        add_entry("decode read unmapped", OP_READ, 32'h3000, '0, '0, 1'b1);
        add_entry("decode write past ram", OP_WRITE, 32'h400, ~w0, '0, 1'b1);
        add_entry("decode write gpio gap", OP_WRITE, 32'h1010, ~w0, '0, 1'b1);
        add_entry("decode read uart gap", OP_READ, 32'h2010, '0, '0, 1'b1);
        add_entry("ram word after decode errors", OP_READ, 32'h000, '0, w0, 1'b0);
    endtask

    task automatic check_value(input string name, input soc_pkg::data_t expected,
                               input soc_pkg::data_t actual);
        if (expected !== actual) begin
            $display("mismatch %s expected %h actual %h", name, expected, actual);
            test_errors++;
        end
    endtask

    // One APB transfer, sampled 1 unit after the falling edge
    // waits counts the access cycles that ended without pready
    task automatic apb_transfer(input logic write, input soc_pkg::addr_t addr,
                                input soc_pkg::data_t data, output soc_pkg::data_t rdata,
                                output logic err, output int waits);
        waits = 0;
        @(negedge clk);
        psel    = 1'b1;
        penable = 1'b0;
        pwrite  = write;
        paddr   = addr;
        pwdata  = data;
        @(negedge clk);
        penable = 1'b1;
        #1;
        while (!pready && waits < 16) begin
            @(negedge clk);
            #1;
            waits++;
        end
        if (!pready) begin
            $display("transfer to address %h never got pready", addr);
            test_errors++;
        end
        rdata = prdata;
        err   = pslverr;
        @(negedge clk);
        psel    = 1'b0;
        penable = 1'b0;
    endtask

    task automatic run_entry(input int i);
        soc_pkg::data_t rdata;
        logic           err;
        int             reads;
        int             waits;
        int             exp_waits;
        test_errors = 0;
        // Only the RAM region, the first 1 KB, adds a wait state
        exp_waits = (addrs[i] < 32'h400) ? 1 : 0;
        case (ops[i])
            OP_WRITE: begin
                apb_transfer(1'b1, addrs[i], datas[i], rdata, err, waits);
                check_value(names[i], 32'(exp_err[i]), 32'(err));
                check_value(names[i], 32'(exp_waits), 32'(waits));
                if (addrs[i] == GPIO_OUT) begin
                    check_value(names[i], {24'd0, datas[i][7:0]}, {24'd0, gpio_out});
                end
            end
            OP_READ: begin
                // Give the pin synchroniser time to settle
                if (addrs[i] == GPIO_IN) begin
                    gpio_in = datas[i][7:0];
                    repeat (3) @(negedge clk);
                end
                apb_transfer(1'b0, addrs[i], '0, rdata, err, waits);
                check_value(names[i], 32'(exp_err[i]), 32'(err));
                check_value(names[i], 32'(exp_waits), 32'(waits));
                check_value(names[i], exp_data[i], rdata);
            end
            default: begin
                reads = 0;
                do begin
                    apb_transfer(1'b0, addrs[i], '0, rdata, err, waits);
                    reads++;
                end while ((rdata & exp_data[i]) == '0 && reads < POLL_LIMIT);
                if ((rdata & exp_data[i]) == '0) begin
                    $display("%s gave up after %0d reads without the bit set", names[i], reads);
                    test_errors++;
                end
                check_value(names[i], 32'(exp_err[i]), 32'(err));
                check_value(names[i], 32'(exp_waits), 32'(waits));
            end
        endcase
        if (test_errors == 0) begin
            pass_count++;
            $display("ok   %s", names[i]);
        end else begin
            fail_count++;
            $display("bad  %s", names[i]);
        end
    endtask

    // Watchdog sized from the table length and the UART frame time
    initial begin
        wait (table_done);
        #((n_entries * 50 + 20 * 10 * CLKS_PER_BIT) * 4);
        $display("watchdog expired before the table finished");
        $display("Simulation failed");
        $finish;
    end

    initial begin
        rst_n      = 1'b0;
        psel       = 1'b0;
        penable    = 1'b0;
        pwrite     = 1'b0;
        paddr      = '0;
        pwdata     = '0;
        gpio_in    = '0;
        seed       = 61086;
        n_entries  = 0;
        pass_count = 0;
        fail_count = 0;
        table_done = 1'b0;
        build_table();
        table_done = 1'b1;
        repeat (8) @(negedge clk);
        rst_n = 1'b1;
        for (int i = 0; i < n_entries; i++) begin
            run_entry(i);
        end
        $display("%0d tests passed, %0d tests failed, %0d assertion failures",
                 pass_count, fail_count, soc_periph_i.asserts_i.assert_errors);
        if (fail_count == 0 && soc_periph_i.asserts_i.assert_errors == 0) begin
            $display("Simulation passed");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

endmodule : soc_periph_tb

/* test/soc_periph_asserts.sv */
/*
 * APB protocol and UART idle checks, bound into soc_periph.
 * tx_busy is taken from the UART instance inside the top level.
 */
module soc_periph_asserts (
    input logic           clk,
    input logic           rst_n,
    input logic           psel,
    input logic           penable,
    input logic           pwrite,
    input soc_pkg::addr_t paddr,
    input soc_pkg::data_t pwdata,
    input logic           pready,
    input logic           pslverr,
    input logic           uart_tx,
    input logic           tx_busy
);

    // Number of failed assertions so far
    int assert_errors = 0;

    // Master holds the transfer while the slave stalls
    apb_hold: assert property (@(posedge clk) disable iff (!rst_n)
        (psel && penable && !pready) |=>
            ($stable(paddr) && $stable(pwrite) && $stable(pwdata)))
        else begin
            assert_errors++;
            $error("APB address or data changed during a wait state");
        end

    apb_err_ready: assert property (@(posedge clk) disable iff (!rst_n)
        pslverr |-> pready)
        else begin
            assert_errors++;
            $error("pslverr high without pready");
        end

    // Line idles high between frames
    uart_idle_high: assert property (@(posedge clk) disable iff (!rst_n)
        !tx_busy |-> uart_tx)
        else begin
            assert_errors++;
            $error("uart_tx low while the transmitter is idle");
        end

endmodule : soc_periph_asserts

bind soc_periph soc_periph_asserts asserts_i (
    .clk     (clk),
    .rst_n   (rst_n),
    .psel    (psel),
    .penable (penable),
    .pwrite  (pwrite),
    .paddr   (paddr),
    .pwdata  (pwdata),
    .pready  (pready),
    .pslverr (pslverr),
    .uart_tx (uart_tx),
    .tx_busy (uart_i.tx_busy)
);

/* verilog/soc_periph.sv */
/*
 * Peripheral subsystem behind one APB slave port: RAM, GPIO and UART.
 * The bus master sits outside. Only RAM accesses insert a wait state.
 */
module soc_periph #(
    parameter int RAM_ADDR_WIDTH = 8,
    parameter int CLKS_PER_BIT   = 8
) (
    input  logic           clk,
    input  logic           rst_n,
    input  logic           psel,
    input  logic           penable,
    input  logic           pwrite,
    input  soc_pkg::addr_t paddr,
    input  soc_pkg::data_t pwdata,
    output soc_pkg::data_t prdata,
    output logic           pready,
    output logic           pslverr,
    input  soc_pkg::gpio_t gpio_in,
    output soc_pkg::gpio_t gpio_out,
    input  logic           uart_rx,
    output logic           uart_tx
);

    // Slave selects and responses
    logic           ram_sel;
    logic           gpio_sel;
    logic           uart_sel;
    soc_pkg::data_t ram_rdata;
    soc_pkg::data_t gpio_rdata;
    soc_pkg::data_t uart_rdata;
    logic           ram_ready;

    apb_decoder decoder_i (
        .psel       (psel),
        .penable    (penable),
        .paddr      (paddr),
        .ram_rdata  (ram_rdata),
        .gpio_rdata (gpio_rdata),
        .uart_rdata (uart_rdata),
        .ram_ready  (ram_ready),
        .ram_sel    (ram_sel),
        .gpio_sel   (gpio_sel),
        .uart_sel   (uart_sel),
        .prdata     (prdata),
        .pready     (pready),
        .pslverr    (pslverr)
    );

    data_ram #(
        .RAM_ADDR_WIDTH (RAM_ADDR_WIDTH)
    ) ram_i (
        .clk     (clk),
        .rst_n   (rst_n),
        .sel     (ram_sel),
        .penable (penable),
        .pwrite  (pwrite),
        .paddr   (paddr),
        .pwdata  (pwdata),
        .rdata   (ram_rdata),
        .ready   (ram_ready)
    );

    gpio gpio_i (
        .clk      (clk),
        .rst_n    (rst_n),
        .sel      (gpio_sel),
        .penable  (penable),
        .pwrite   (pwrite),
        .paddr    (paddr),
        .pwdata   (pwdata),
        .port_in  (gpio_in),
        .rdata    (gpio_rdata),
        .port_out (gpio_out)
    );

    uart #(
        .CLKS_PER_BIT (CLKS_PER_BIT)
    ) uart_i (
        .clk     (clk),
        .rst_n   (rst_n),
        .sel     (uart_sel),
        .penable (penable),
        .pwrite  (pwrite),
        .paddr   (paddr),
        .pwdata  (pwdata),
        .rx      (uart_rx),
        .rdata   (uart_rdata),
        .tx      (uart_tx)
    );

endmodule : soc_periph

/* verilog/uart.sv */
/*
 * 8N1 UART, LSB first. A TXDATA write while busy is dropped, and a new
 * received byte overwrites an unread one. CLKS_PER_BIT must be at least 4.
 */
module uart #(
    parameter int CLKS_PER_BIT = 8
) (
    input  logic           clk,
    input  logic           rst_n,
    input  logic           sel,
    input  logic           penable,
    input  logic           pwrite,
    input  soc_pkg::addr_t paddr,
    input  soc_pkg::data_t pwdata,
    input  logic           rx,
    output soc_pkg::data_t rdata,
    output logic           tx
);

    localparam int CNT_W = $clog2(CLKS_PER_BIT);
    localparam logic [CNT_W-1:0] BIT_LAST  = CNT_W'(CLKS_PER_BIT - 1);
    localparam logic [CNT_W-1:0] HALF_LAST = CNT_W'(CLKS_PER_BIT / 2 - 1);

    soc_pkg::uart_state_t tx_state;
    soc_pkg::uart_state_t rx_state;
    logic [CNT_W-1:0]     tx_cnt;
    logic [CNT_W-1:0]     rx_cnt;
    logic [2:0]           tx_bit;
    logic [2:0]           rx_bit;
    soc_pkg::uart_byte_t  tx_shift;
    soc_pkg::uart_byte_t  rx_shift;
    soc_pkg::uart_byte_t  rx_data;
    logic                 tx_busy;
    logic                 rx_valid;
    logic                 rx_meta;
    logic                 rx_sync;
    logic                 tx_start;
    logic                 tx_bit_end;
    logic                 rx_sample;
    logic                 rx_done;
    logic                 rd_rxdata;

    // Register access decode, all in the first access cycle
    assign tx_start = sel && penable && pwrite && !tx_busy &&
                      (paddr[3:0] == soc_pkg::UART_TXDATA_OFS);
    assign rd_rxdata = sel && penable && !pwrite &&
                       (paddr[3:0] == soc_pkg::UART_RXDATA_OFS);

    assign tx_busy    = tx_state != soc_pkg::UART_IDLE;
    assign tx_bit_end = tx_cnt == BIT_LAST;

    // Transmit FSM
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            tx_state <= soc_pkg::UART_IDLE;
            tx_cnt   <= '0;
            tx_bit   <= '0;
            tx       <= 1'b1;
        end else begin
            tx_cnt <= (tx_state == soc_pkg::UART_IDLE || tx_bit_end) ? '0 : tx_cnt + 1'b1;
            case (tx_state)
                soc_pkg::UART_IDLE: begin
                    tx <= 1'b1;
                    if (tx_start) begin
                        tx_state <= soc_pkg::UART_START;
                        tx       <= 1'b0;
                    end
                end
                soc_pkg::UART_START: begin
                    if (tx_bit_end) begin
                        tx_state <= soc_pkg::UART_DATA;
                        tx_bit   <= '0;
                        tx       <= tx_shift[0];
                    end
                end
                soc_pkg::UART_DATA: begin
                    if (tx_bit_end) begin
                        if (tx_bit == 3'd7) begin
                            tx_state <= soc_pkg::UART_STOP;
                            tx       <= 1'b1;
                        end else begin
                            tx_bit <= tx_bit + 1'b1;
                            tx     <= tx_shift[1];
                        end
                    end
                end
                default: begin
                    if (tx_bit_end) begin
                        tx_state <= soc_pkg::UART_IDLE;
                    end
                end
            endcase
        end
    end

    // Transmit shifter
    always_ff @(posedge clk) begin
        if (tx_start) begin
            tx_shift <= pwdata[7:0];
        end else if (tx_state == soc_pkg::UART_DATA && tx_bit_end) begin
            tx_shift <= tx_shift >> 1;
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            rx_meta <= 1'b1;
            rx_sync <= 1'b1;
        end else begin
            rx_meta <= rx;
            rx_sync <= rx_meta;
        end
    end

    // Mid-bit sample points once the start bit is confirmed
    assign rx_sample = (rx_state == soc_pkg::UART_DATA) && (rx_cnt == BIT_LAST);
    assign rx_done   = (rx_state == soc_pkg::UART_STOP) && (rx_cnt == BIT_LAST);

    // Receive FSM
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            rx_state <= soc_pkg::UART_IDLE;
            rx_cnt   <= '0;
            rx_bit   <= '0;
            rx_valid <= 1'b0;
        end else begin
            rx_cnt <= rx_cnt + 1'b1;
            case (rx_state)
                soc_pkg::UART_IDLE: begin
                    rx_cnt <= '0;
                    if (!rx_sync) begin
                        rx_state <= soc_pkg::UART_START;
                    end
                end
                soc_pkg::UART_START: begin
                    if (rx_cnt == HALF_LAST) begin
                        rx_cnt <= '0;
                        rx_bit <= '0;
                        // A glitch shorter than half a bit is not a start
                        rx_state <= rx_sync ? soc_pkg::UART_IDLE : soc_pkg::UART_DATA;
                    end
                end
                soc_pkg::UART_DATA: begin
                    if (rx_sample) begin
                        rx_cnt <= '0;
                        rx_bit <= rx_bit + 1'b1;
                        if (rx_bit == 3'd7) begin
                            rx_state <= soc_pkg::UART_STOP;
                        end
                    end
                end
                default: begin
                    if (rx_done) begin
                        rx_state <= soc_pkg::UART_IDLE;
                    end
                end
            endcase
            // A new byte wins over a clearing read in the same cycle
            if (rx_done && rx_sync) begin
                rx_valid <= 1'b1;
            end else if (rd_rxdata) begin
                rx_valid <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (rx_sample) begin
            rx_shift <= {rx_sync, rx_shift[7:1]};
        end
        if (rx_done && rx_sync) begin
            rx_data <= rx_shift;
        end
    end

    always_comb begin
        case (paddr[3:0])
            soc_pkg::UART_STATUS_OFS: rdata = {30'd0, rx_valid, tx_busy};
            soc_pkg::UART_RXDATA_OFS: rdata = {24'd0, rx_data};
            default:                  rdata = '0;
        endcase
    end

endmodule : uart

/* verilog/gpio.sv */
/*
 * 8-bit GPIO. OUT is read/write, IN is read only and two cycles late
 * because of the synchroniser. Unused offsets read zero.
 */
module gpio (
    input  logic           clk,
    input  logic           rst_n,
    input  logic           sel,
    input  logic           penable,
    input  logic           pwrite,
    input  soc_pkg::addr_t paddr,
    input  soc_pkg::data_t pwdata,
    input  soc_pkg::gpio_t port_in,
    output soc_pkg::data_t rdata,
    output soc_pkg::gpio_t port_out
);

    soc_pkg::gpio_t in_meta;
    soc_pkg::gpio_t in_sync;
    logic           wr_out;

    assign wr_out = sel && penable && pwrite &&
                    (paddr[3:0] == soc_pkg::GPIO_OUT_OFS);

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            port_out <= '0;
        end else if (wr_out) begin
            port_out <= pwdata[7:0];
        end
    end

    // Two-flop synchroniser for the pins
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            in_meta <= '0;
            in_sync <= '0;
        end else begin
            in_meta <= port_in;
            in_sync <= in_meta;
        end
    end

    always_comb begin
        case (paddr[3:0])
            soc_pkg::GPIO_OUT_OFS: rdata = {24'd0, port_out};
            soc_pkg::GPIO_IN_OFS:  rdata = {24'd0, in_sync};
            default:               rdata = '0;
        endcase
    end

endmodule : gpio

/* verilog/data_ram.sv */
/*
 * Word RAM on APB, byte lanes ignored. Every transfer takes one wait state.
 * RAM_ADDR_WIDTH must be 8 or less to fit the 1 KB region.
 */
module data_ram #(
    parameter int RAM_ADDR_WIDTH = 8
) (
    input  logic           clk,
    input  logic           rst_n,
    input  logic           sel,
    input  logic           penable,
    input  logic           pwrite,
    input  soc_pkg::addr_t paddr,
    input  soc_pkg::data_t pwdata,
    output soc_pkg::data_t rdata,
    output logic           ready
);

    soc_pkg::data_t mem [2**RAM_ADDR_WIDTH];

    logic [RAM_ADDR_WIDTH-1:0] word_addr;
    logic                      wait_q;

    assign word_addr = paddr[RAM_ADDR_WIDTH+1:2];

    // High in the second access cycle only
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            wait_q <= 1'b0;
        end else if (sel && penable) begin
            wait_q <= !wait_q;
        end else begin
            wait_q <= 1'b0;
        end
    end

    assign ready = sel && penable && wait_q;

    // Read data settles during the first access cycle
    always_ff @(posedge clk) begin
        if (ready && pwrite) begin
            mem[word_addr] <= pwdata;
        end
        if (sel) begin
            rdata <= mem[word_addr];
        end
    end

endmodule : data_ram

/* verilog/apb_decoder.sv */
/*
 * APB address decoder for three slaves. Only the RAM can stall the bus,
 * GPIO and UART always finish in their first access cycle.
 * A miss finishes at once with pslverr high and zero read data.
 */
module apb_decoder (
    input  logic           psel,
    input  logic           penable,
    input  soc_pkg::addr_t paddr,
    input  soc_pkg::data_t ram_rdata,
    input  soc_pkg::data_t gpio_rdata,
    input  soc_pkg::data_t uart_rdata,
    input  logic           ram_ready,
    output logic           ram_sel,
    output logic           gpio_sel,
    output logic           uart_sel,
    output soc_pkg::data_t prdata,
    output logic           pready,
    output logic           pslverr
);

    logic ram_hit;
    logic gpio_hit;
    logic uart_hit;
    logic access;

    // Region match on the upper address bits
    assign ram_hit = paddr[31:soc_pkg::RAM_SPAN_BITS] ==
                     soc_pkg::RAM_BASE[31:soc_pkg::RAM_SPAN_BITS];
    assign gpio_hit = paddr[31:soc_pkg::PERIPH_SPAN_BITS] ==
                      soc_pkg::GPIO_BASE[31:soc_pkg::PERIPH_SPAN_BITS];
    assign uart_hit = paddr[31:soc_pkg::PERIPH_SPAN_BITS] ==
                      soc_pkg::UART_BASE[31:soc_pkg::PERIPH_SPAN_BITS];

    assign ram_sel  = psel && ram_hit;
    assign gpio_sel = psel && gpio_hit;
    assign uart_sel = psel && uart_hit;

    assign access = psel && penable;

    // Response path back to the master
    always_comb begin
        prdata  = '0;
        pready  = 1'b0;
        pslverr = 1'b0;
        if (access) begin
            if (ram_hit) begin
                prdata = ram_rdata;
                pready = ram_ready;
            end else if (gpio_hit) begin
                prdata = gpio_rdata;
                pready = 1'b1;
            end else if (uart_hit) begin
                prdata = uart_rdata;
                pready = 1'b1;
            end else begin
                // Unmapped address
                pready  = 1'b1;
                pslverr = 1'b1;
            end
        end
    end

endmodule : apb_decoder

/* verilog/soc_pkg.sv */
/*
 * Shared types and the APB address map of the peripheral subsystem.
 * The RAM region is 1 KB. The GPIO and UART regions are 16 bytes each.
 */
package soc_pkg;

    // Bus and port widths
    typedef logic [31:0] addr_t;
    typedef logic [31:0] data_t;
    typedef logic [7:0]  gpio_t;
    typedef logic [7:0]  uart_byte_t;

    // Shared by the UART transmit and receive machines
    typedef enum logic [1:0] {
        UART_IDLE,
        UART_START,
        UART_DATA,
        UART_STOP
    } uart_state_t;

    // Region bases
    localparam addr_t RAM_BASE  = 32'h0000_0000;
    localparam addr_t GPIO_BASE = 32'h0000_1000;
    localparam addr_t UART_BASE = 32'h0000_2000;

    // Low address bits inside a region, 1 KB and 16 bytes
    localparam int RAM_SPAN_BITS    = 10;
    localparam int PERIPH_SPAN_BITS = 4;

    // GPIO register offsets
    localparam logic [3:0] GPIO_OUT_OFS = 4'h0;
    localparam logic [3:0] GPIO_IN_OFS  = 4'h4;

    // UART register offsets
    localparam logic [3:0] UART_TXDATA_OFS = 4'h0;
    localparam logic [3:0] UART_STATUS_OFS = 4'h4;
    localparam logic [3:0] UART_RXDATA_OFS = 4'h8;

endpackage : soc_pkg
